//--- logic/memTypesPkg.sv
// Memory stage types for the CPU request side and the external SRAM pins.
`default_nettype none

package memTypesPkg;

	localparam int CpuAddrWidth = 16; // word address from the CPU.
	localparam int WordWidth = 32;
	localparam int HalfWidth = WordWidth / 2; // one SRAM access.
	localparam int SramAddrWidth = CpuAddrWidth + 2; // zero top bit and half select.

	typedef logic [CpuAddrWidth-1:0] cpuAddrT;
	typedef logic [WordWidth-1:0] wordT;
	typedef logic [HalfWidth-1:0] halfT;
	typedef logic [SramAddrWidth-1:0] sramAddrT;

	// Held by the CPU for as long as notReady is high.
	typedef struct packed
	{
		logic read; // read wins when both are set.
		logic write;
		cpuAddrT addr;
		wordT writeData;
	} memReqT;

endpackage

`default_nettype wire

//--- logic/sramCtrlPkg.sv
// Controller state encoding and the per-phase control word sent to the datapath.
`default_nettype none

package sramCtrlPkg;

	// The low half is handled while still in idle, so no separate low state.
	typedef enum logic [1:0]
	{
		idle = 2'd0,
		readHigh = 2'd1,
		writeHigh = 2'd2,
		settle = 2'd3
	} ctrlStateT;

	typedef struct packed
	{
		logic highHalf; // address and write data half.
		logic drive; // bus driver enable.
		logic weN; // active low.
		logic captureLow;
		logic captureHigh;
	} phaseCtrlT;

	// bus released, no write, no capture.
	localparam phaseCtrlT PhaseRest = '{
		highHalf: 1'b0,
		drive: 1'b0,
		weN: 1'b1,
		captureLow: 1'b0,
		captureHigh: 1'b0
	};

endpackage

`default_nettype wire

//--- logic/sramCtrlFsm.sv
// Access sequencer for low half, high half and settle wait, producing the CPU stall.
`timescale 1ns/1ps
`default_nettype none

module sramCtrlFsm
(
	input wire logic clk,
	input wire logic rst,
	input wire memTypesPkg::memReqT req,
	input wire logic timerBusy,
	output logic timerLoad,
	output logic notReady,
	output sramCtrlPkg::phaseCtrlT phase
);
	import sramCtrlPkg::*;

	ctrlStateT state;
	ctrlStateT nextState;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= idle;
		end
		else
		begin
			state <= nextState;
		end
	end

	// Cycle 0 of an access is spent in idle, with the low half on the pins.
	always_comb
	begin
		nextState = state;
		timerLoad = 1'b0;
		notReady = 1'b0;
		phase = PhaseRest;
		unique case (state)
			idle:
			begin
				if (req.read)
				begin
					nextState = readHigh;
					timerLoad = 1'b1; // settle time starts with the access.
					notReady = 1'b1;
					phase.captureLow = 1'b1;
				end
				else if (req.write)
				begin
					nextState = writeHigh;
					timerLoad = 1'b1;
					notReady = 1'b1;
					phase.drive = 1'b1;
					phase.weN = 1'b0; // low half written this cycle.
				end
			end
			readHigh:
			begin
				nextState = settle;
				notReady = 1'b1;
				phase.highHalf = 1'b1;
				phase.captureHigh = 1'b1;
			end
			writeHigh:
			begin
				nextState = settle;
				notReady = 1'b1;
				phase.highHalf = 1'b1;
				phase.drive = 1'b1;
				phase.weN = 1'b0;
			end
			settle:
			begin
				notReady = timerBusy; // falls in the last cycle of settle.
				if (!timerBusy)
				begin
					nextState = idle;
				end
			end
		endcase
	end

endmodule

`default_nettype wire

//--- logic/stallTimer.sv
// Settle-time down-counter, loaded at the start of each access and saturating at zero.
`timescale 1ns/1ps
`default_nettype none

module stallTimer
#(
	parameter int WaitCycles = 4
)
(
	input wire logic clk,
	input wire logic rst,
	input wire logic timerLoad,
	output logic timerBusy
);
	localparam int CountWidth = $clog2(WaitCycles + 1);

	typedef logic [CountWidth-1:0] countT;

	localparam countT LoadValue = countT'(WaitCycles);

	countT count;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			count <= '0;
		end
		else if (timerLoad)
		begin
			count <= LoadValue;
		end
		else if (count != '0)
		begin
			count <= count - countT'(1); // holds at zero.
		end
	end

	assign timerBusy = (count != '0);

endmodule

`default_nettype wire

//--- logic/sramDatapath.sv
// SRAM address forming, tristate write-half driver and read-word assembly.
`timescale 1ns/1ps
`default_nettype none

module sramDatapath
(
	input wire logic clk,
	input wire logic rst,
	input wire memTypesPkg::memReqT req,
	input wire sramCtrlPkg::phaseCtrlT phase,
	output memTypesPkg::sramAddrT sramAddr,
	output logic sramWeN,
	inout wire memTypesPkg::halfT sramData,
	output memTypesPkg::wordT readData
);
	import memTypesPkg::*;

	halfT writeHalf;
	halfT lowCapture;
	halfT highCapture;

	// Word address sits between a zero top bit and the half select.
	assign sramAddr = {1'b0, req.addr, phase.highHalf};

	assign writeHalf = phase.highHalf ? req.writeData[WordWidth-1:HalfWidth]
		: req.writeData[HalfWidth-1:0];

	assign sramData = phase.drive ? writeHalf : {HalfWidth{1'bz}}; // released otherwise.

	assign sramWeN = phase.weN;

	// The SRAM is asynchronous and the address holds all cycle, so the
	// rising edge that ends the strobe cycle samples settled data.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			lowCapture <= '0;
			highCapture <= '0;
		end
		else
		begin
			if (phase.captureLow)
			begin
				lowCapture <= sramData;
			end
			if (phase.captureHigh)
			begin
				highCapture <= sramData;
			end
		end
	end

	assign readData = {highCapture, lowCapture};

endmodule

`default_nettype wire

//--- logic/sramController.sv
// Memory-stage SRAM controller top connecting sequencer, stall timer and datapath.
`timescale 1ns/1ps
`default_nettype none

module sramController
#(
	parameter int WaitCycles = 4 // at least 2.
)
(
	input wire logic clk,
	input wire logic rst,
	input wire memTypesPkg::memReqT req,
	output memTypesPkg::wordT readData,
	output logic notReady,
	output memTypesPkg::sramAddrT sramAddr,
	output logic sramWeN,
	inout wire memTypesPkg::halfT sramData
);
	import sramCtrlPkg::*;

	phaseCtrlT phase;
	logic timerLoad;
	logic timerBusy;

	sramCtrlFsm fsm
	(
		.clk(clk),
		.rst(rst),
		.req(req),
		.timerBusy(timerBusy),
		.timerLoad(timerLoad),
		.notReady(notReady),
		.phase(phase)
	);

	stallTimer
	#(
		.WaitCycles(WaitCycles)
	)
	timer
	(
		.clk(clk),
		.rst(rst),
		.timerLoad(timerLoad),
		.timerBusy(timerBusy)
	);

	sramDatapath datapath
	(
		.clk(clk),
		.rst(rst),
		.req(req),
		.phase(phase),
		.sramAddr(sramAddr),
		.sramWeN(sramWeN),
		.sramData(sramData),
		.readData(readData)
	);

endmodule

`default_nettype wire

//--- tb/sramModel.sv
// Behavioral asynchronous 16-bit SRAM on a shared data bus with an active-low write enable.
`timescale 1ns/1ps
`default_nettype none

module sramModel
(
	input wire logic clk,
	input wire memTypesPkg::sramAddrT addr,
	input wire logic weN,
	inout wire memTypesPkg::halfT data
);
	import memTypesPkg::*;

	localparam int Depth = 1 << SramAddrWidth;

	halfT cells [Depth];

	initial
	begin
		for (int i = 0; i < Depth; i++)
		begin
			cells[sramAddrT'(i)] <= halfT'(i) ^ halfT'((i >> 16) * 16'h5a5b) ^ 16'h3c00;
		end
	end

	// output drive follows weN as there is no separate output enable.
	assign data = weN ? cells[addr] : {HalfWidth{1'bz}};

	// weN stays low across both halves while the address moves,
	// so each written half is committed mid-cycle.
	always @(negedge clk)
	begin
		if (!weN)
		begin
			cells[addr] <= data;
		end
	end

endmodule

`default_nettype wire

//--- tb/sramControllerAssert.sv
// Bound checks on SRAM bus ownership and the access sequencing of the controller.
`timescale 1ns/1ps
`default_nettype none

module sramControllerAssert
(
	input wire logic clk,
	input wire logic rst,
	input wire memTypesPkg::memReqT req,
	input wire logic notReady,
	input wire memTypesPkg::sramAddrT sramAddr,
	input wire logic sramWeN,
	input wire memTypesPkg::halfT sramData
);
	int unsigned failCount = 0;

	writeDriven: assert property (@(posedge clk) disable iff (rst)
		!sramWeN |-> !$isunknown(sramData))
	else
	begin
		$error("sramWeN low while sramData is not driven");
		failCount++;
	end

	// the FSM sits in idle exactly when notReady was low one cycle earlier.
	stallOnRequest: assert property (@(posedge clk) disable iff (rst)
		(!$past(notReady) && (req.read || req.write)) |-> notReady)
	else
	begin
		$error("notReady did not rise with a request in idle");
		failCount++;
	end

	highHalfNext: assert property (@(posedge clk) disable iff (rst)
		(!$past(notReady) && (req.read || req.write)) |=> sramAddr[0])
	else
	begin
		$error("high half not addressed in the cycle after acceptance");
		failCount++;
	end

endmodule

bind sramController sramControllerAssert checks
(
	.clk(clk),
	.rst(rst),
	.req(req),
	.notReady(notReady),
	.sramAddr(sramAddr),
	.sramWeN(sramWeN),
	.sramData(sramData)
);

`default_nettype wire

//--- tb/sramControllerTb.sv
// Directed testbench for the SRAM controller against a behavioral SRAM and a reference memory.
`timescale 1ns/1ps
`default_nettype none

module sramControllerTb;
	import memTypesPkg::*;

	localparam int WaitCycles = 4;
	localparam int ResetCycles = 8;
	localparam int TimeoutCycles = 200 * (WaitCycles + 3) + ResetCycles; // access plus idle gap.
	localparam cpuAddrT RandomBase = 16'h0100;

	logic clk = 1'b0;
	logic rst;
	memReqT req;
	wordT readData;
	logic notReady;
	sramAddrT sramAddr;
	logic sramWeN;
	wire halfT sramData;
	wordT refMem [1 << CpuAddrWidth];
	int seed = 32'h26d5679b;
	int unsigned cycleCount = 0;
	cpuAddrT lastAddr;

	sramController #(.WaitCycles(WaitCycles)) dut
	(
		.clk(clk),
		.rst(rst),
		.req(req),
		.readData(readData),
		.notReady(notReady),
		.sramAddr(sramAddr),
		.sramWeN(sramWeN),
		.sramData(sramData)
	);

	sramModel sram
	(
		.clk(clk),
		.addr(sramAddr),
		.weN(sramWeN),
		.data(sramData)
	);

	always #5 clk = ~clk;

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1);
	endtask

	always @(negedge clk)
	begin
		cycleCount++;
		if (cycleCount > TimeoutCycles)
		begin
			abortRun("timed out before all tests finished");
		end
		else if (dut.checks.failCount != 0)
		begin
			abortRun("a bound assertion on the controller failed");
		end
	end

	task automatic checkWord(input string name, input wordT got, input wordT expected);
		assert (got === expected)
		else abortRun($sformatf("Error: %s = %h, expected %h", name, got, expected));
	endtask

	// zero top bit, word address, half select.
	function automatic wordT modelWord(input cpuAddrT addr);
		return {sram.cells[{1'b0, addr, 1'b1}], sram.cells[{1'b0, addr, 1'b0}]};
	endfunction

	// holds the request until notReady falls and checks the stall length.
	task automatic runAccess(input logic rd, input logic wr, input cpuAddrT addr,
		input wordT data, output wordT result);
		int stallCycles;
		bit done;
		stallCycles = 0;
		done = 1'b0;
		@(posedge clk);
		req <= '{read: rd, write: wr, addr: addr, writeData: data};
		while (!done)
		begin
			@(negedge clk);
			if (notReady)
			begin
				stallCycles++;
			end
			else
			begin
				done = 1'b1;
			end
		end
		result = readData;
		assert (stallCycles == WaitCycles + 1)
		else abortRun($sformatf("Error: notReady stall = %h cycles, expected %h",
			stallCycles, WaitCycles + 1));
		@(posedge clk);
		req <= '0;
	endtask

	task automatic writeWord(input cpuAddrT addr, input wordT data);
		wordT ignored;
		runAccess(1'b0, 1'b1, addr, data, ignored);
		refMem[addr] = data;
	endtask

	task automatic readWord(input cpuAddrT addr);
		wordT result;
		runAccess(1'b1, 1'b0, addr, $random(seed), result);
		checkWord("readData", result, refMem[addr]);
	endtask

	task automatic checkResetState();
		repeat (5)
		begin
			@(negedge clk);
			checkWord("notReady", wordT'(notReady), '0);
			checkWord("sramWeN", wordT'(sramWeN), 32'h1);
			checkWord("sramData", wordT'(sramData), wordT'(sram.cells[sramAddr])); // clash if driven.
			checkWord("readData", readData, '0);
		end
	endtask

	task automatic testWriteReadBack();
		repeat (2)
		begin
			lastAddr = 16'h2000 | cpuAddrT'($random(seed) & 32'hfff);
			writeWord(lastAddr, $random(seed));
			readWord(lastAddr);
		end
	endtask

	task automatic testMemoryLayout();
		cpuAddrT addr;
		wordT data;
		wordT below;
		wordT above;
		addr = 16'h5000 | cpuAddrT'($random(seed) & 32'hfff);
		data = $random(seed);
		below = modelWord(addr - cpuAddrT'(1));
		above = modelWord(addr + cpuAddrT'(1));
		writeWord(addr, data);
		checkWord("sram.cells low half", wordT'(sram.cells[{1'b0, addr, 1'b0}]),
			{16'h0, data[15:0]});
		checkWord("sram.cells high half", wordT'(sram.cells[{1'b0, addr, 1'b1}]),
			{16'h0, data[31:16]});
		checkWord("sram word below", modelWord(addr - cpuAddrT'(1)), below);
		checkWord("sram word above", modelWord(addr + cpuAddrT'(1)), above);
	endtask

	// runAccess checks the stall of each of these.
	task automatic testStallLength();
		cpuAddrT addr;
		addr = 16'h7000 | cpuAddrT'($random(seed) & 32'hfff);
		writeWord(addr, $random(seed));
		readWord(addr);
		writeWord(addr, $random(seed));
		readWord(addr);
	endtask

	task automatic testReadPriority();
		wordT result;
		runAccess(1'b1, 1'b1, lastAddr, ~refMem[lastAddr], result);
		checkWord("readData", result, refMem[lastAddr]);
		checkWord("sram word", modelWord(lastAddr), refMem[lastAddr]);
	endtask

	task automatic testRandomTraffic();
		int i;
		int r;
		cpuAddrT addr;
		for (i = 0; i < 64; i++)
		begin
			refMem[RandomBase + cpuAddrT'(i)] = modelWord(RandomBase + cpuAddrT'(i)); // fill.
		end
		repeat (150)
		begin
			r = $random(seed);
			addr = RandomBase + cpuAddrT'(r & 63);
			if (r[8])
			begin
				readWord(addr);
			end
			else
			begin
				writeWord(addr, $random(seed));
			end
		end
	endtask

	initial
	begin
		rst = 1'b1;
		req = '0;
		repeat (ResetCycles) @(posedge clk);
		rst <= 1'b0;
		checkResetState();
		testWriteReadBack();
		testMemoryLayout();
		testStallLength();
		testReadPriority();
		testRandomTraffic();
		@(negedge clk);
		if (dut.checks.failCount == 0)
		begin
			$display("test passed");
			$finish;
		end
		else
		begin
			abortRun("a bound assertion on the controller failed");
		end
	end

endmodule

`default_nettype wire

//--- sramController.f
logic/memTypesPkg.sv
logic/sramCtrlPkg.sv
logic/sramCtrlFsm.sv
logic/stallTimer.sv
logic/sramDatapath.sv
logic/sramController.sv
tb/sramModel.sv
tb/sramControllerAssert.sv
tb/sramControllerTb.sv

//--- Makefile
TOP = sramControllerTb

all: run

build:
	verilator --binary --timing --assert -f sramController.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -qx "test passed" sim.log

lint:
	verilator --lint-only --timing --assert -f sramController.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
